//--- sim.f
+incdir+include
design/alu_pipe_pkg.sv
design/decode_stage.sv
design/pipe_regs.sv
design/exec_stage.sv
design/alu_pipe_top.sv
test/tb_alu_pipe.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_alu_pipe -f sim.f
	out=$$(./obj_dir/Vtb_alu_pipe); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

//--- test/alu_pipe_input.txt
# I <inst hex> <rd hex> <data hex> expects that writeback, X <inst hex> expects none,
# F <inst hex> is presented with a flush, S <cycles> stalls, T <name> ends a test
I 7205 1 0005
I 743D 2 FFFD
I 761F 3 001F
I 1858 4 0024
I 2A50 5 0008
I 3CD0 6 001D
I 4E50 7 FFFD
I 58C8 4 001A
I 6A88 5 0001
I 6C50 6 0000
T alu_basic
I 720A 1 000A
I 1448 2 0014
I 1650 3 001E
I 28C8 4 0014
I 727F 1 0009
I 1248 1 0012
I 1A60 5 0026
T forwarding
X 0650
X F650
X 1050
X 7005
I 1C18 6 001E
I 1E00 7 0000
T no_write
I 7207 1 0007
I 1448 2 000E
S 3
I 1688 3 0015
S 2
I 28D0 4 0007
T stall
I 7A01 5 0001
X 7C02
F 7E03
I 13B8 1 001E
I 1568 2 0002
T flush

//--- test/tb_alu_pipe.sv
// Testbench for the ALU pipeline top level, replays the command file under test/ and scores o_wb
`timescale 1ns/10ps
`default_nettype none

module tb_alu_pipe;

	localparam string STIM_FILE = "test/alu_pipe_input.txt";
	localparam alu_pipe_pkg::inst_t DECOY = 16'h7E3F;  // ADDI r7, r0, -1

	logic                      clk;
	logic                      rst_n;
	logic                      i_inst_valid;
	alu_pipe_pkg::inst_t       i_inst;
	logic                      i_stall;
	logic                      i_flush;
	alu_pipe_pkg::write_back_t o_wb;

	alu_pipe_pkg::write_back_t exp_q [$];  // Expected writebacks in file order
	int                        errors;
	int                        test_mark;  // Error count when the current test began
	int                        tests_passed;
	int                        tests_failed;
	int                        file_lines;
	int                        fd;
	int                        ch;
	bit                        lines_known;

	alu_pipe_top dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_inst_valid (i_inst_valid),
		.i_inst       (i_inst),
		.i_stall      (i_stall),
		.i_flush      (i_flush),
		.o_wb         (o_wb)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic check_writeback(input alu_pipe_pkg::write_back_t exp);
		if (o_wb.rw_addr !== exp.rw_addr)
		begin
			$display("[ERROR] o_wb.rw_addr expected 0x%h got 0x%h", exp.rw_addr, o_wb.rw_addr);
			errors++;
		end
		if (o_wb.rw_data !== exp.rw_data)
		begin
			$display("[ERROR] o_wb.rw_data expected 0x%h got 0x%h", exp.rw_data, o_wb.rw_data);
			errors++;
		end
	endtask

	task automatic check_wb_idle();
		if (o_wb.uses_rw !== 1'b0)
		begin
			$display("[ERROR] o_wb.uses_rw expected 0x0 got 0x%h", o_wb.uses_rw);
			errors++;
		end
	endtask

	// Only unstalled edges commit, a stalled o_wb is the same record again
	always @(posedge clk)
	begin
		if (!i_stall && o_wb.uses_rw === 1'b1)
		begin
			if (exp_q.size() == 0)
			begin
				$display("Writeback to r%0d with data 0x%h arrived when none was expected",
					o_wb.rw_addr, o_wb.rw_data);
				errors++;
			end
			else
				check_writeback(exp_q.pop_front());
		end
	end

	task automatic issue_word(input alu_pipe_pkg::inst_t word, input logic flush);
		i_inst_valid = 1'b1;
		i_inst       = word;
		i_flush      = flush;
		@(posedge clk);
		@(negedge clk);
		i_inst_valid = 1'b0;
		i_flush      = 1'b0;
	endtask

	// Decoy stays on the input and must not enter the pipeline
	task automatic hold_stall(input int cycles);
		alu_pipe_pkg::write_back_t held;
		held         = o_wb;
		i_stall      = 1'b1;
		i_inst_valid = 1'b1;
		i_inst       = DECOY;
		repeat (cycles)
		begin
			@(posedge clk);
			@(negedge clk);
			if (o_wb !== held)
			begin
				$display("[ERROR] o_wb expected 0x%h got 0x%h while stalled", held, o_wb);
				errors++;
			end
		end
		i_stall      = 1'b0;
		i_inst_valid = 1'b0;
	endtask

	task automatic report_test(input logic [8*24-1:0] name);
		if (errors == test_mark)
		begin
			$display("Test %0s passed", name);
			tests_passed++;
		end
		else
		begin
			$display("Test %0s failed with %0d errors", name, errors - test_mark);
			tests_failed++;
		end
		test_mark = errors;
	endtask

	task automatic finish_test(input logic [8*24-1:0] name);
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < 8)
		begin
			@(negedge clk);
			waited++;
		end
		if (exp_q.size() != 0)
		begin
			$display("Test %0s: %0d expected writebacks never arrived", name, exp_q.size());
			errors += exp_q.size();
			exp_q.delete();
		end
		repeat (2) @(negedge clk);  // Last write settles in the register file
		report_test(name);
	endtask

	task automatic run_commands(input int f);
		int                        c;
		int                        got;
		int                        cycles;
		logic [7:0]                cmd;
		alu_pipe_pkg::inst_t       word;
		alu_pipe_pkg::reg_addr_t   addr;
		alu_pipe_pkg::data_t       data;
		alu_pipe_pkg::write_back_t exp;
		logic [8*24-1:0]           name;
		c = $fgetc(f);
		while (c != -1)
		begin
			cmd = c[7:0];
			case (cmd)
				"#":
				begin
					while (c != -1 && c != 10)
						c = $fgetc(f);
				end
				"I":
				begin
					got = $fscanf(f, "%h %h %h", word, addr, data);
					if (got != 3)
					begin
						$display("Malformed instruction line in the stimulus file");
						errors++;
					end
					exp.uses_rw = 1'b1;
					exp.rw_addr = addr;
					exp.rw_data = data;
					exp_q.push_back(exp);
					issue_word(word, 1'b0);
				end
				"X":
				begin
					got = $fscanf(f, "%h", word);
					issue_word(word, 1'b0);
				end
				"F":
				begin
					got = $fscanf(f, "%h", word);
					issue_word(word, 1'b1);
				end
				"S":
				begin
					got = $fscanf(f, "%d", cycles);
					hold_stall(cycles);
				end
				"T":
				begin
					got = $fscanf(f, "%s", name);
					finish_test(name);
				end
				default:
				begin
				end
			endcase
			c = $fgetc(f);
		end
	endtask

	initial
	begin
		rst_n        = 1'b0;
		i_inst_valid = 1'b1;  // Live word during reset must stay out
		i_inst       = DECOY;
		i_stall      = 1'b0;
		i_flush      = 1'b0;
		errors       = 0;
		test_mark    = 0;
		tests_passed = 0;
		tests_failed = 0;
		file_lines   = 0;

		// Line count sets the watchdog budget
		fd = $fopen(STIM_FILE, "r");
		if (fd != 0)
		begin
			ch = $fgetc(fd);
			while (ch != -1)
			begin
				if (ch == 10)
					file_lines++;
				ch = $fgetc(fd);
			end
			$fclose(fd);
		end
		lines_known = 1'b1;

		repeat (2)
		begin
			@(posedge clk);
			@(negedge clk);
			check_wb_idle();
		end
		rst_n        = 1'b1;
		i_inst_valid = 1'b0;
		repeat (2)
		begin
			@(posedge clk);
			@(negedge clk);
			check_wb_idle();
		end
		report_test("reset");

		fd = $fopen(STIM_FILE, "r");
		if (fd == 0)
		begin
			$display("Could not open the stimulus file %0s", STIM_FILE);
			errors++;
		end
		else
		begin
			run_commands(fd);
			$fclose(fd);
		end

		$display("Tests passed: %0d  failed: %0d", tests_passed, tests_failed);
		if (errors == 0 && tests_failed == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// Margin of ten lines covers reset and the final drain
	initial
	begin
		wait (lines_known);
		repeat ((file_lines + 10) * 20) @(posedge clk);
		$display("Timeout: the command stream did not finish within %0d cycles",
			(file_lines + 10) * 20);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- design/alu_pipe_top.sv
// Top level of the ALU pipeline that chains decode, pr_d2e, execute and pr_e2w and drives o_wb
`timescale 1ns/10ps
`default_nettype none

module alu_pipe_top (
	input  wire                              clk,
	input  wire                              rst_n,
	input  wire                              i_inst_valid,
	input  wire alu_pipe_pkg::inst_t         i_inst,
	input  wire                              i_stall,
	input  wire                              i_flush,
	output alu_pipe_pkg::write_back_t        o_wb
);

	alu_pipe_pkg::hazard_ctl_t hc;
	alu_pipe_pkg::alu_input_t  d_alu_input;  // Decode side of pr_d2e
	alu_pipe_pkg::alu_pass_t   d_pass;
	alu_pipe_pkg::alu_input_t  e_alu_input;  // Execute side of pr_d2e
	alu_pipe_pkg::alu_pass_t   e_pass;
	alu_pipe_pkg::write_back_t ex_wb;        // Also the execute forwarding path

	assign hc = '{stall: i_stall, flush: i_flush};

	decode_stage u_decode (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_hc         (hc),
		.i_inst_valid (i_inst_valid),
		.i_inst       (i_inst),
		.i_ex_fwd     (ex_wb),
		.i_wb         (o_wb),
		.o_alu_input  (d_alu_input),
		.o_pass       (d_pass)
	);

	pr_d2e u_pr_d2e (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_hc        (hc),
		.i_alu_input (d_alu_input),
		.i_pass      (d_pass),
		.o_alu_input (e_alu_input),
		.o_pass      (e_pass)
	);

	exec_stage u_exec (
		.i_alu_input (e_alu_input),
		.i_pass      (e_pass),
		.o_wb        (ex_wb)
	);

	pr_e2w u_pr_e2w (
		.clk   (clk),
		.rst_n (rst_n),
		.i_hc  (hc),
		.i_wb  (ex_wb),
		.o_wb  (o_wb)
	);

endmodule

`default_nettype wire

//--- design/exec_stage.sv
// Combinational ALU between pr_d2e and pr_e2w, forming the writeback record
`timescale 1ns/10ps
`default_nettype none

module exec_stage (
	input  wire alu_pipe_pkg::alu_input_t    i_alu_input,
	input  wire alu_pipe_pkg::alu_pass_t     i_pass,
	output alu_pipe_pkg::write_back_t        o_wb
);

	alu_pipe_pkg::data_t result;
	logic                lt;

	// Signed compare for SLT
	assign lt = $signed(i_alu_input.op1) < $signed(i_alu_input.op2);

	always_comb
	begin
		case (i_alu_input.alu_ctl)
			alu_pipe_pkg::ALUCTL_ADD: result = i_alu_input.op1 + i_alu_input.op2;
			alu_pipe_pkg::ALUCTL_SUB: result = i_alu_input.op1 - i_alu_input.op2;
			alu_pipe_pkg::ALUCTL_AND: result = i_alu_input.op1 & i_alu_input.op2;
			alu_pipe_pkg::ALUCTL_OR:  result = i_alu_input.op1 | i_alu_input.op2;
			alu_pipe_pkg::ALUCTL_XOR: result = i_alu_input.op1 ^ i_alu_input.op2;
			alu_pipe_pkg::ALUCTL_SLT: result = alu_pipe_pkg::data_t'(lt);  // 0 or 1
			default:                  result = '0;
		endcase
	end

	always_comb
	begin
		// Bubbles and non-writing ops never raise uses_rw
		o_wb.uses_rw = i_alu_input.valid && i_pass.uses_rw;
		o_wb.rw_addr = i_pass.rw_addr;
		o_wb.rw_data = result;
	end

endmodule

`default_nettype wire

//--- design/pipe_regs.sv
// Stall/flush pipeline registers between decode, execute and writeback
`timescale 1ns/10ps
`default_nettype none

module pr_d2e (
	input  wire                              clk,
	input  wire                              rst_n,
	input  wire alu_pipe_pkg::hazard_ctl_t   i_hc,
	input  wire alu_pipe_pkg::alu_input_t    i_alu_input,
	input  wire alu_pipe_pkg::alu_pass_t     i_pass,
	output alu_pipe_pkg::alu_input_t         o_alu_input,
	output alu_pipe_pkg::alu_pass_t          o_pass
);

	localparam alu_pipe_pkg::alu_input_t IN_BUBBLE = '{
		valid:   1'b0,
		alu_ctl: alu_pipe_pkg::ALUCTL_NOP,
		op1:     '0,
		op2:     '0
	};
	localparam alu_pipe_pkg::alu_pass_t PASS_BUBBLE = '{uses_rw: 1'b0, rw_addr: '0};

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			o_alu_input <= IN_BUBBLE;
			o_pass      <= PASS_BUBBLE;
		end
		else
		begin
			if (!i_hc.stall)  // Stall holds everything, flush included
			begin
				if (i_hc.flush)
				begin
					o_alu_input <= IN_BUBBLE;
					o_pass      <= PASS_BUBBLE;
				end
				else
				begin
					o_alu_input <= i_alu_input;
					o_pass      <= i_pass;
				end
			end
		end
	end

endmodule

module pr_e2w (
	input  wire                              clk,
	input  wire                              rst_n,
	input  wire alu_pipe_pkg::hazard_ctl_t   i_hc,
	input  wire alu_pipe_pkg::write_back_t   i_wb,
	output alu_pipe_pkg::write_back_t        o_wb
);

	localparam alu_pipe_pkg::write_back_t WB_BUBBLE = '{
		uses_rw: 1'b0,
		rw_addr: '0,
		rw_data: '0
	};

	// Record already here on a flush still writes, the decode stage sees o_wb
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			o_wb <= WB_BUBBLE;
		else
		begin
			if (!i_hc.stall)
			begin
				if (i_hc.flush)
					o_wb <= WB_BUBBLE;
				else
					o_wb <= i_wb;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/decode_stage.sv
// Decode stage with the register file and operand forwarding, feeding pr_d2e
`timescale 1ns/10ps
`default_nettype none
`include "alu_pipe_settings.svh"

module decode_stage (
	input  wire                              clk,
	input  wire                              rst_n,
	input  wire alu_pipe_pkg::hazard_ctl_t   i_hc,
	input  wire                              i_inst_valid,
	input  wire alu_pipe_pkg::inst_t         i_inst,
	input  wire alu_pipe_pkg::write_back_t   i_ex_fwd,  // Result now in execute
	input  wire alu_pipe_pkg::write_back_t   i_wb,      // Result in pr_e2w
	output alu_pipe_pkg::alu_input_t         o_alu_input,
	output alu_pipe_pkg::alu_pass_t          o_pass
);

	alu_pipe_pkg::data_t     rf [`ALU_PIPE_NREGS];
	alu_pipe_pkg::opcode_t   opcode;
	alu_pipe_pkg::reg_addr_t rd;
	alu_pipe_pkg::reg_addr_t rs;
	alu_pipe_pkg::reg_addr_t rt;
	logic [5:0]              imm;
	alu_pipe_pkg::data_t     imm_ext;
	alu_pipe_pkg::data_t     rs_val;
	alu_pipe_pkg::data_t     rt_val;
	alu_pipe_pkg::alu_ctl_t  alu_ctl;
	logic                    writes_rd;

	// r0 first, then the youngest producer, then the older one, then the file
	function automatic alu_pipe_pkg::data_t fwd_read(
		input alu_pipe_pkg::reg_addr_t   addr,
		input alu_pipe_pkg::write_back_t ex,
		input alu_pipe_pkg::write_back_t wb,
		input alu_pipe_pkg::data_t       rf_val
	);
		alu_pipe_pkg::data_t val;
		if (addr == '0)
			val = '0;
		else if (ex.uses_rw && ex.rw_addr == addr)
			val = ex.rw_data;
		else if (wb.uses_rw && wb.rw_addr == addr)
			val = wb.rw_data;
		else
			val = rf_val;
		return val;
	endfunction

	assign opcode  = alu_pipe_pkg::opcode_t'(i_inst[15:12]);
	assign rd      = i_inst[11:9];
	assign rs      = i_inst[8:6];
	assign rt      = i_inst[5:3];
	assign imm     = i_inst[5:0];  // ADDI only, overlaps rt
	assign imm_ext = {{(`ALU_PIPE_DATA_W - 6){imm[5]}}, imm};

	always_comb
	begin
		alu_ctl   = alu_pipe_pkg::ALUCTL_NOP;
		writes_rd = 1'b1;
		case (opcode)
			alu_pipe_pkg::OP_ADD:  alu_ctl = alu_pipe_pkg::ALUCTL_ADD;
			alu_pipe_pkg::OP_SUB:  alu_ctl = alu_pipe_pkg::ALUCTL_SUB;
			alu_pipe_pkg::OP_AND:  alu_ctl = alu_pipe_pkg::ALUCTL_AND;
			alu_pipe_pkg::OP_OR:   alu_ctl = alu_pipe_pkg::ALUCTL_OR;
			alu_pipe_pkg::OP_XOR:  alu_ctl = alu_pipe_pkg::ALUCTL_XOR;
			alu_pipe_pkg::OP_SLT:  alu_ctl = alu_pipe_pkg::ALUCTL_SLT;
			alu_pipe_pkg::OP_ADDI: alu_ctl = alu_pipe_pkg::ALUCTL_ADD;
			default:               writes_rd = 1'b0;  // NOP and unused codes
		endcase
	end

	assign rs_val = fwd_read(rs, i_ex_fwd, i_wb, rf[rs]);
	assign rt_val = fwd_read(rt, i_ex_fwd, i_wb, rf[rt]);

	always_comb
	begin
		o_alu_input.valid   = i_inst_valid;
		o_alu_input.alu_ctl = alu_ctl;
		o_alu_input.op1     = rs_val;
		o_alu_input.op2     = (opcode == alu_pipe_pkg::OP_ADDI) ? imm_ext : rt_val;
		// Writes to r0 are dropped here so they never forward
		o_pass.uses_rw      = i_inst_valid && writes_rd && (rd != '0);
		o_pass.rw_addr      = rd;
	end

	// Register file write from the writeback stage
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < `ALU_PIPE_NREGS; i++)
				rf[i] <= '0;
		end
		else if (!i_hc.stall && i_wb.uses_rw && i_wb.rw_addr != '0)
			rf[i_wb.rw_addr] <= i_wb.rw_data;
	end

endmodule

`default_nettype wire

//--- design/alu_pipe_pkg.sv
// Shared types for the ALU pipeline stages, referenced by scoped name from each module
`default_nettype none
`include "alu_pipe_settings.svh"

package alu_pipe_pkg;

	typedef logic [`ALU_PIPE_DATA_W-1:0]  data_t;
	typedef logic [`ALU_PIPE_RADDR_W-1:0] reg_addr_t;
	typedef logic [`ALU_PIPE_INST_W-1:0]  inst_t;

	// Opcode field, bits 15..12 of the instruction
	typedef enum logic [3:0] {
		OP_NOP  = 4'h0,
		OP_ADD  = 4'h1,
		OP_SUB  = 4'h2,
		OP_AND  = 4'h3,
		OP_OR   = 4'h4,
		OP_XOR  = 4'h5,
		OP_SLT  = 4'h6,
		OP_ADDI = 4'h7  // Codes above this decode as NOP
	} opcode_t;

	typedef enum logic [2:0] {
		ALUCTL_NOP,
		ALUCTL_ADD,
		ALUCTL_SUB,
		ALUCTL_AND,
		ALUCTL_OR,
		ALUCTL_XOR,
		ALUCTL_SLT
	} alu_ctl_t;

	typedef struct packed {
		logic     valid;
		alu_ctl_t alu_ctl;
		data_t    op1;
		data_t    op2;
	} alu_input_t;

	// Destination info that rides alongside the operands
	typedef struct packed {
		logic      uses_rw;
		reg_addr_t rw_addr;
	} alu_pass_t;

	typedef struct packed {
		logic      uses_rw;
		reg_addr_t rw_addr;
		data_t     rw_data;
	} write_back_t;

	typedef struct packed {
		logic stall;
		logic flush;
	} hazard_ctl_t;

endpackage

`default_nettype wire

//--- include/alu_pipe_settings.svh
// Width and size settings for the ALU pipeline, included by the package and the decode stage
`ifndef ALU_PIPE_SETTINGS_SVH
`define ALU_PIPE_SETTINGS_SVH

`define ALU_PIPE_DATA_W 16  // Data word width

`define ALU_PIPE_NREGS 8  // Register file depth

// Must cover ALU_PIPE_NREGS
`define ALU_PIPE_RADDR_W 3

`define ALU_PIPE_INST_W 16  // Instruction word width

`endif
